// File: verification/ebi_trace.txt
# W addr data | R addr expected | M addr minimum | S sample | N idle clocks
# E opcode channel payload | Q irq level | T test name, all numbers hex except N and Q
T reset_state
R 0 3300
R 9 0000
R a 0000
T cmd_assembly
E a5 3c 12345678
W 1 a53c
W 2 0000
W 3 0000
W 4 1234
W 5 5678
N 10
T timed_release
W 1 1102
W 2 0000
W 3 0020
W 4 cafe
W 5 f00d
N 40
E 11 02 cafef00d
W 8 0001
N 60
M 9 0020
W 7 0001
R 9 0000
R 9 0000
T sample_path
S 1111
S 2222
S 3333
# each pop refreshes the held word from the new head
R 6 dead
R 6 2222
R 6 3333
T status_irq
R 0 3300
Q 0
S 00aa
N 4
Q 1
R 0 3200
Q 0
W 1 7700
W 2 ffff
W 3 ffff
W 4 0000
W 5 0001
W 5 0002
W 5 0003
W 5 0004
W 5 0005
W 5 0006
W 5 0007
W 5 0008
R 0 c200

// File: project.f
+incdir+common
common/ebi_pkg.sv
hdl/sync_fifo.sv
hdl/cmd_scheduler.sv
ebi_bridge/ebi_bridge.sv
hdl/ebi_subsystem_top.sv
verification/ebi_sva.sv
verification/ebi_checker.sv
verification/ebi_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module ebi_tb -o ebi_sim
./obj_dir/ebi_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// File: verification/ebi_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ebi_tb;

  logic                clk;
  logic                rst;
  logic [15:0]         data_in;
  logic [18:0]         addr;
  logic                rd;
  logic                wr;
  logic                cs;
  ebi_pkg::sample_t    sample_in;
  logic [15:0]         data_out;
  logic                irq;
  logic [31:0]         global_time;
  ebi_pkg::cmd_event_t cmd_event;

  ebi_subsystem_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .data_in     (data_in),
    .addr        (addr),
    .rd          (rd),
    .wr          (wr),
    .cs          (cs),
    .sample_in   (sample_in),
    .data_out    (data_out),
    .irq         (irq),
    .global_time (global_time),
    .cmd_event   (cmd_event)
  );

  ebi_checker i_chk (
    .clk         (clk),
    .rst         (rst),
    .cs          (cs),
    .rd          (rd),
    .wr          (wr),
    .addr        (addr),
    .data_out    (data_out),
    .irq         (irq),
    .global_time (global_time),
    .cmd_event   (cmd_event)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------------------------------------
  // host bus and sample port
  // ------------------------------------------------------------
  task automatic bus_write(input logic [7:0] a, input logic [15:0] d);
    @(posedge clk);
    cs      <= 1'b1;
    wr      <= 1'b1;
    addr    <= {11'd0, a};
    data_in <= d;
    repeat (4) @(posedge clk);   // strobe held 4 clocks
    cs <= 1'b0;
    wr <= 1'b0;
    repeat (4) @(posedge clk);   // idle gap
  endtask

  task automatic bus_read(input logic [7:0] a);
    @(posedge clk);
    cs   <= 1'b1;
    rd   <= 1'b1;
    addr <= {11'd0, a};
    repeat (4) @(posedge clk);
    cs <= 1'b0;
    rd <= 1'b0;
    repeat (4) @(posedge clk);
  endtask

  task automatic push_sample(input logic [15:0] d);
    @(posedge clk);
    sample_in <= '{valid: 1'b1, data: d};
    @(posedge clk);
    sample_in.valid <= 1'b0;
  endtask

  // let queued events arrive before a test is closed
  task automatic drain_events();
    int waited;
    waited = 0;
    while (i_chk.pending_events() != 0 && waited < 400) begin
      @(posedge clk);
      waited++;
    end
    if (i_chk.pending_events() != 0)
      i_chk.note_failure("an expected command event never arrived");
  endtask

  // ------------------------------------------------------------
  // trace player
  // ------------------------------------------------------------
  initial begin : player
    integer      fd;
    integer      code;
    integer      n;
    string       op;
    string       name;
    string       line;
    logic [31:0] v1, v2, v3;
    logic        in_test;

    cs        = 1'b0;
    rd        = 1'b0;
    wr        = 1'b0;
    addr      = '0;
    data_in   = '0;
    sample_in = '0;
    rst       = 1'b1;
    in_test   = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);

    fd = $fopen("verification/ebi_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file");
      $display("TEST FAIL");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", op);
        if (code != 1) break;
        case (op)
          "#": code = $fgets(line, fd);   // comment line
          "T": begin
            code = $fscanf(fd, "%s", name);
            if (in_test) begin
              drain_events();
              i_chk.end_test();
            end
            i_chk.begin_test(name);
            in_test = 1'b1;
          end
          "W": begin
            code = $fscanf(fd, "%h %h", v1, v2);
            bus_write(v1[7:0], v2[15:0]);
          end
          "R", "M": begin
            code = $fscanf(fd, "%h %h", v1, v2);
            i_chk.expect_read(v2[15:0], op == "M");   // M is a lower bound
            bus_read(v1[7:0]);
          end
          "S": begin
            code = $fscanf(fd, "%h", v1);
            push_sample(v1[15:0]);
          end
          "N": begin
            code = $fscanf(fd, "%d", n);
            repeat (n) @(posedge clk);
          end
          "E": begin
            code = $fscanf(fd, "%h %h %h", v1, v2, v3);
            i_chk.expect_event({v1[7:0], v2[7:0], v3});
          end
          "Q": begin
            code = $fscanf(fd, "%d", n);
            @(negedge clk);
            i_chk.check_irq(n != 0);
          end
          default: i_chk.note_failure({"unknown trace opcode ", op});
        endcase
      end
      $fclose(fd);
      if (in_test) begin
        drain_events();
        i_chk.end_test();
      end
      $display("tests passed %0d, failed %0d", i_chk.tests_passed, i_chk.tests_failed);
      if (i_chk.tests_failed == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verification/ebi_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "ebi_settings.svh"

module ebi_checker (
  input wire logic                clk,
  input wire logic                rst,
  input wire logic                cs,
  input wire logic                rd,
  input wire logic                wr,
  input wire logic [18:0]         addr,
  input wire logic [15:0]         data_out,
  input wire logic                irq,
  input wire logic [31:0]         global_time,
  input wire ebi_pkg::cmd_event_t cmd_event
);

  string       test_name;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  logic        read_pending;
  logic        read_at_least;
  logic [15:0] read_exp;
  logic        rd_seen;
  logic [47:0] event_q [$];   // opcode, channel, payload
  logic [31:0] time_exp;
  logic        time_run_exp;
  logic        wr_open;       // write strobe seen, end not handled yet
  logic [7:0]  wr_reg;
  int          wr_age;        // negedges since the strobe dropped
  logic        time_flagged;  // one timebase error per test

  initial begin
    test_name     = "none";
    test_errors   = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    read_pending  = 1'b0;
    read_at_least = 1'b0;
    read_exp      = '0;
    rd_seen       = 1'b0;
    time_exp      = '0;
    time_run_exp  = 1'b0;
    wr_open       = 1'b0;
    wr_reg        = '0;
    wr_age        = 0;
    time_flagged  = 1'b0;
  end

  // ------------------------------------------------------------
  // calls from the testbench
  // ------------------------------------------------------------
  task automatic begin_test(input string n);
    test_name    = n;
    test_errors  = 0;
    time_flagged = 1'b0;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, test_errors);
    end
  endtask

  task automatic note_failure(input string msg);
    $display("test %s: %s", test_name, msg);
    test_errors++;
  endtask

  task automatic expect_read(input logic [15:0] v, input logic at_least);
    read_exp      = v;
    read_at_least = at_least;
    read_pending  = 1'b1;
  endtask

  task automatic expect_event(input logic [47:0] ev);
    event_q.push_back(ev);
  endtask

  task automatic check_irq(input logic exp);
    if (irq !== exp) begin
      $display("Error %s: irq expected %b, actual %b", test_name, exp, irq);
      test_errors++;
    end
  endtask

  function automatic int pending_events();
    return event_q.size();
  endfunction

  // ------------------------------------------------------------
  // monitor, sampled away from the driving edge
  // ------------------------------------------------------------
  always @(negedge clk) begin : watch
    logic [47:0] exp_ev;
    logic [47:0] act_ev;
    // data_out holds its last value once the strobe drops
    if (rd_seen && !(cs && rd) && read_pending) begin
      read_pending = 1'b0;
      if (read_at_least && (data_out >= read_exp) !== 1'b1) begin
        $display("Error %s: read expected at least %h, actual %h",
                 test_name, read_exp, data_out);
        test_errors++;
      end else if (!read_at_least && data_out !== read_exp) begin
        $display("Error %s: read expected %h, actual %h", test_name, read_exp, data_out);
        test_errors++;
      end
    end
    rd_seen = cs && rd;
    if (!rst && cmd_event.valid === 1'b1) begin
      act_ev = {cmd_event.opcode, cmd_event.channel, cmd_event.payload};
      if (event_q.size() == 0) begin
        note_failure("a command event arrived when none was expected");
      end else begin
        exp_ev = event_q.pop_front();
        if (act_ev !== exp_ev) begin
          $display("Error %s: event expected %h, actual %h", test_name, exp_ev, act_ev);
          test_errors++;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // timebase model
  // ------------------------------------------------------------

  // a reset or run write shows one clock after its done cycle
  always @(negedge clk) begin : timebase
    if (rst) begin
      time_exp     = '0;
      time_run_exp = 1'b0;
      wr_open      = 1'b0;
      wr_age       = 0;
    end else begin
      if (time_run_exp) time_exp = time_exp + 32'd1;
      if (cs && wr) begin
        wr_open = 1'b1;
        wr_reg  = addr[7:0];
        wr_age  = 0;
      end else if (wr_open) begin
        wr_age++;
        if (wr_age == 3) begin
          wr_open = 1'b0;
          if (wr_reg == `EBI_ADDR_TIME_RESET) begin
            time_exp     = '0;
            time_run_exp = 1'b0;
          end else if (wr_reg == `EBI_ADDR_TIME_RUN) begin
            time_run_exp = 1'b1;
          end
        end
      end
      if (global_time !== time_exp && !time_flagged) begin
        $display("Error %s: global_time expected %h, actual %h",
                 test_name, time_exp, global_time);
        test_errors++;
        time_flagged = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/ebi_sva.sv
`timescale 1ns/1ps
`default_nettype none

module ebi_sva (
  input wire logic                 clk,
  input wire logic                 rst,
  input wire logic [6:0]           state,
  input wire logic                 cmd_push,
  input wire ebi_pkg::fifo_flags_t cmd_flags,
  input wire logic                 sample_pop,
  input wire logic                 irq
);

  a_state_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("bridge state is not one-hot");

  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    cmd_push |-> !cmd_flags.full)
    else $error("command push while command fifo full");

  a_pop_single: assert property (@(posedge clk) disable iff (rst)
    sample_pop |=> !sample_pop)
    else $error("sample pop wider than one clock");

  a_irq_reset: assert property (@(posedge clk) rst |=> !irq)
    else $error("irq high right after reset");

endmodule

bind ebi_bridge ebi_sva u_sva (
  .clk        (clk),
  .rst        (rst),
  .state      (state),
  .cmd_push   (cmd_push),
  .cmd_flags  (cmd_flags),
  .sample_pop (sample_pop),
  .irq        (irq)
);

`default_nettype wire

// File: hdl/ebi_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ebi_settings.svh"

module ebi_subsystem_top (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic [15:0]      data_in,
  input  wire logic [18:0]      addr,
  input  wire logic             rd,
  input  wire logic             wr,
  input  wire logic             cs,
  input  wire ebi_pkg::sample_t sample_in,
  output logic [15:0]           data_out,
  output logic                  irq,
  output logic [31:0]           global_time,
  output ebi_pkg::cmd_event_t   cmd_event
);

  // command path
  ebi_pkg::cmd_word_u   cmd_word;
  ebi_pkg::cmd_word_u   cmd_head;
  ebi_pkg::fifo_flags_t cmd_flags;
  logic                 cmd_push;
  logic                 cmd_pop;

  // sample path
  ebi_pkg::fifo_flags_t sample_flags;
  logic [15:0]          sample_head;
  logic                 sample_pop;

  ebi_bridge u_bridge (
    .clk          (clk),
    .rst          (rst),
    .data_in      (data_in),
    .addr         (addr),
    .rd           (rd),
    .wr           (wr),
    .cs           (cs),
    .cmd_flags    (cmd_flags),
    .sample_flags (sample_flags),
    .sample_head  (sample_head),
    .data_out     (data_out),
    .irq          (irq),
    .cmd_push     (cmd_push),
    .cmd_word     (cmd_word),
    .sample_pop   (sample_pop),
    .global_time  (global_time)
  );

  sync_fifo #(.WIDTH(80), .DEPTH(`EBI_CMD_FIFO_DEPTH)) u_cmd_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (cmd_push),
    .push_data (cmd_word),
    .pop       (cmd_pop),
    .head      (cmd_head),
    .flags     (cmd_flags)
  );

  sync_fifo #(.WIDTH(16), .DEPTH(`EBI_SAMPLE_FIFO_DEPTH)) u_sample_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (sample_in.valid),
    .push_data (sample_in.data),
    .pop       (sample_pop),
    .head      (sample_head),
    .flags     (sample_flags)
  );

  cmd_scheduler u_scheduler (
    .clk         (clk),
    .rst         (rst),
    .head        (cmd_head),
    .flags       (cmd_flags),
    .global_time (global_time),
    .pop         (cmd_pop),
    .cmd_event   (cmd_event)
  );

endmodule

`default_nettype wire

// File: ebi_bridge/ebi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "ebi_settings.svh"

module ebi_bridge (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic [15:0]         data_in,
  input  wire logic [18:0]         addr,
  input  wire logic                rd,
  input  wire logic                wr,
  input  wire logic                cs,
  input  wire ebi_pkg::fifo_flags_t cmd_flags,
  input  wire ebi_pkg::fifo_flags_t sample_flags,
  input  wire logic [15:0]         sample_head,
  output logic [15:0]              data_out,
  output logic                     irq,
  output logic                     cmd_push,
  output ebi_pkg::cmd_word_u       cmd_word,
  output logic                     sample_pop,
  output logic [31:0]              global_time
);

  // one-hot control states
  localparam logic [6:0] st_idle           = 7'b0000001;
  localparam logic [6:0] st_fetch          = 7'b0000010;
  localparam logic [6:0] st_cmd_commit     = 7'b0000100;
  localparam logic [6:0] st_time_reset     = 7'b0001000;
  localparam logic [6:0] st_time_run       = 7'b0010000;
  localparam logic [6:0] st_sample_read    = 7'b0100000;
  localparam logic [6:0] st_sample_capture = 7'b1000000;

  logic [6:0]  state;
  logic [6:0]  next_state;
  logic [7:0]  reg_addr;
  logic        rd_d, rd_dd;
  logic        wr_d, wr_dd;
  logic        rd_done, wr_done;
  logic        load_cmd;
  logic        capture_sample;
  logic        reset_time;
  logic        run_time;
  logic        time_running;
  logic [15:0] live_status;
  logic [15:0] status_reg;
  logic [15:0] status_snap;
  logic [15:0] sample_held;
  logic [15:0] read_word;

  assign reg_addr = addr[7:0];

  // ------------------------------------------------------------
  // strobe end detection
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_d  <= 1'b0;
      rd_dd <= 1'b0;
      wr_d  <= 1'b0;
      wr_dd <= 1'b0;
    end else begin
      rd_d  <= cs & rd;
      rd_dd <= rd_d;
      wr_d  <= cs & wr;
      wr_dd <= wr_d;
    end
  end

  assign rd_done = rd_dd & ~rd_d;   // two clocks after strobe drop
  assign wr_done = wr_dd & ~wr_d;

  // ------------------------------------------------------------
  // control FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) state <= st_idle;
    else     state <= next_state;
  end

  always_comb begin
    next_state     = state;
    load_cmd       = 1'b0;
    cmd_push       = 1'b0;
    sample_pop     = 1'b0;
    capture_sample = 1'b0;
    reset_time     = 1'b0;
    run_time       = 1'b0;
    case (state)
      st_idle: next_state = st_fetch;
      st_fetch: begin
        if (cs & wr) begin
          load_cmd = (reg_addr >= `EBI_ADDR_CMD_WORD1) && (reg_addr <= `EBI_ADDR_CMD_WORD5);
          if (reg_addr == `EBI_ADDR_CMD_WORD5)      next_state = st_cmd_commit;
          else if (reg_addr == `EBI_ADDR_TIME_RESET) next_state = st_time_reset;
          else if (reg_addr == `EBI_ADDR_TIME_RUN)   next_state = st_time_run;
        end else if (cs & rd && reg_addr == `EBI_ADDR_NEXT_SAMPLE) begin
          next_state = st_sample_read;
        end
      end
      st_cmd_commit: begin
        if (wr_done) begin
          cmd_push   = ~cmd_flags.full;   // a full fifo loses the command
          next_state = st_fetch;
        end
      end
      st_time_reset: begin
        if (wr_done) begin
          reset_time = 1'b1;
          next_state = st_fetch;
        end
      end
      st_time_run: begin
        if (wr_done) begin
          run_time   = 1'b1;
          next_state = st_fetch;
        end
      end
      st_sample_read: begin
        // host has the held word, fetch the next one
        if (rd_done) begin
          sample_pop = ~sample_flags.empty;
          next_state = sample_flags.empty ? st_fetch : st_sample_capture;
        end
      end
      st_sample_capture: begin
        capture_sample = 1'b1;   // new head is out now
        next_state     = st_fetch;
      end
      default: next_state = st_idle;
    endcase
  end

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (load_cmd) cmd_word.words[reg_addr[2:0]] <= data_in;
  end

  assign live_status = {cmd_flags, sample_flags, 8'h00};

  always_ff @(posedge clk) begin
    if (rst) begin
      status_reg  <= live_status;   // start with no pending change
      status_snap <= live_status;
      irq         <= 1'b0;
    end else begin
      status_reg <= live_status;
      irq        <= status_reg != status_snap;
      if (cs & rd && reg_addr == `EBI_ADDR_STATUS) status_snap <= status_reg;
    end
  end

  always_comb begin
    case (reg_addr)
      `EBI_ADDR_STATUS:      read_word = status_reg;
      `EBI_ADDR_NEXT_SAMPLE: read_word = sample_held;
      `EBI_ADDR_TIME_LOW:    read_word = global_time[15:0];
      `EBI_ADDR_TIME_HIGH:   read_word = global_time[31:16];
      default:               read_word = 16'h0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (cs & rd) data_out <= read_word;
  end

  always_ff @(posedge clk) begin
    if (rst)                 sample_held <= 16'hDEAD;
    else if (capture_sample) sample_held <= sample_head;
  end

  // timebase, a reset write also stops it
  always_ff @(posedge clk) begin
    if (rst) begin
      global_time  <= 32'd0;
      time_running <= 1'b0;
    end else begin
      if (reset_time) begin
        global_time  <= 32'd0;
        time_running <= 1'b0;
      end else if (time_running) begin
        global_time <= global_time + 32'd1;
      end
      if (run_time) time_running <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/cmd_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_scheduler (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire ebi_pkg::cmd_word_u   head,
  input  wire ebi_pkg::fifo_flags_t flags,
  input  wire logic [31:0]          global_time,
  output logic                      pop,
  output ebi_pkg::cmd_event_t       cmd_event
);

  logic due;
  logic settle;   // blocks the clock right after a pop

  // ------------------------------------------------------------
  // release decision
  // ------------------------------------------------------------

  // head is only meaningful when the fifo holds something
  assign due = ~flags.empty && (head.fields.timestamp <= global_time);
  assign pop = due & ~settle;

  // ------------------------------------------------------------
  // event register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (pop) begin
      cmd_event.opcode  <= head.fields.opcode;
      cmd_event.channel <= head.fields.channel;
      cmd_event.payload <= head.fields.payload;
    end
    if (rst) begin
      cmd_event.valid <= 1'b0;
      settle          <= 1'b0;
    end else begin
      cmd_event.valid <= pop;   // one clock only
      settle          <= pop;   // fifo flags catch up meanwhile
    end
  end

endmodule

`default_nettype wire

// File: hdl/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "ebi_settings.svh"

module sync_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 16
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             push,
  input  wire logic [WIDTH-1:0] push_data,
  input  wire logic             pop,
  output logic [WIDTH-1:0]      head,
  output ebi_pkg::fifo_flags_t  flags
);

  localparam int ptr_w = $clog2(DEPTH);

  // flag thresholds at count width
  localparam logic [ptr_w:0] lvl_full = (ptr_w+1)'(DEPTH);
  localparam logic [ptr_w:0] lvl_af   = (ptr_w+1)'(DEPTH - `EBI_ALMOST_MARGIN);
  localparam logic [ptr_w:0] lvl_ae   = (ptr_w+1)'(`EBI_ALMOST_MARGIN);
  localparam logic [ptr_w-1:0] last   = (ptr_w)'(DEPTH - 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push & ~flags.full;    // overflow dropped
  assign do_pop  = pop & ~flags.empty;

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == last) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == last) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head = mem[rd_ptr];   // first word falls through

  assign flags = '{almost_full:  count >= lvl_af,
                   full:         count == lvl_full,
                   almost_empty: count <= lvl_ae,
                   empty:        count == '0};

endmodule

`default_nettype wire

// File: common/ebi_pkg.sv
`default_nettype none

package ebi_pkg;

  // ------------------------------------------------------------
  // command word
  // ------------------------------------------------------------

  // field layout, msb first
  typedef struct packed {
    logic [7:0]  opcode;
    logic [7:0]  channel;
    logic [31:0] timestamp;   // release time in global_time ticks
    logic [31:0] payload;
  } cmd_fields_t;

  // host writes five words, word1 lands in bits 79:64
  typedef union packed {
    logic [1:5][15:0] words;
    cmd_fields_t      fields;
  } cmd_word_u;

  // ------------------------------------------------------------
  // streams and flags
  // ------------------------------------------------------------

  typedef struct packed {
    logic        valid;
    logic [7:0]  opcode;
    logic [7:0]  channel;
    logic [31:0] payload;
  } cmd_event_t;

  typedef struct packed {
    logic        valid;
    logic [15:0] data;
  } sample_t;

  // same bit order as a status nibble
  typedef struct packed {
    logic almost_full;
    logic full;
    logic almost_empty;
    logic empty;
  } fifo_flags_t;

endpackage

`default_nettype wire

// File: common/ebi_settings.svh
`ifndef EBI_SETTINGS_SVH
`define EBI_SETTINGS_SVH

// fifo sizing, in entries
`define EBI_CMD_FIFO_DEPTH    8
`define EBI_SAMPLE_FIFO_DEPTH 16
`define EBI_ALMOST_MARGIN     2   // entries from full or empty

// host register map, low byte of addr
`define EBI_ADDR_STATUS       8'd0
`define EBI_ADDR_CMD_WORD1    8'd1
`define EBI_ADDR_CMD_WORD2    8'd2
`define EBI_ADDR_CMD_WORD3    8'd3
`define EBI_ADDR_CMD_WORD4    8'd4
`define EBI_ADDR_CMD_WORD5    8'd5
`define EBI_ADDR_NEXT_SAMPLE  8'd6
`define EBI_ADDR_TIME_RESET   8'd7
`define EBI_ADDR_TIME_RUN     8'd8
`define EBI_ADDR_TIME_LOW     8'd9
`define EBI_ADDR_TIME_HIGH    8'd10

`endif
